/* Makefile */
SOURCES = $(wildcard logic/*.sv dv/*.sv)

.PHONY: run clean

obj_dir/VcpuTb: mipsCore.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps --top-module cpuTb \
		-f mipsCore.f -o VcpuTb

# The run fails unless the testbench printed its pass line.
run: obj_dir/VcpuTb
	@out="$$(./obj_dir/VcpuTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir

/* dv/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;
    localparam int clockPeriod = 40;
    localparam int maxRows = 64;
    localparam int kindNone = 0;
    localparam int kindReg = 1;
    localparam int kindStore = 2;

    logic        clock;
    logic        reset;
    logic        start;
    logic        loadValid;
    logic [5:0]  loadAddr;
    logic [31:0] loadData;
    logic        loadReady;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbValue;
    logic        storeValid;
    logic [31:0] storeAddr;
    logic [31:0] storeData;
    logic        done;

    // Program table, one row per instruction word.
    logic [31:0] rowWord [maxRows];
    int          rowTest [maxRows];
    int          rowKind [maxRows];
    logic [31:0] rowWhere [maxRows];
    logic [31:0] rowValue [maxRows];
    int          rowCount;
    logic        tableReady;

    // Register and memory model, used while the table is built.
    logic [31:0] model [32];
    logic [31:0] modelMem [64];
    int          curTest;
    int          testPos;
    int          skipCount;
    integer      seed;

    // Retirements seen at the DUT ports during one run.
    logic [31:0] evKind [$];
    logic [31:0] evWhere [$];
    logic [31:0] evValue [$];
    int          errorCount;
    int          passCount;
    int          failCount;

    cpu #(.imemDepth(64), .dmemDepth(64)) u_cpu (
        .clock(clock), .reset(reset), .start(start),
        .loadValid(loadValid), .loadAddr(loadAddr), .loadData(loadData),
        .loadReady(loadReady), .wbValid(wbValid), .wbReg(wbReg), .wbValue(wbValue),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
        .done(done)
    );

    always #(clockPeriod / 2) clock = ~clock;

    function automatic logic [31:0] rWord(logic [5:0] fn, int rs, int rt, int rd, int shamt);
        return {cpuPkg::opRType, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
    endfunction

    function automatic logic [31:0] iWord(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] signExtend(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic checkValue(string what, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            errorCount++;
        end
    endtask

    task automatic newTest(int t);
        curTest = t;
        testPos = 0;
        skipCount = 0;
    endtask

    // Rows behind a taken branch, a jump or a halt expect nothing.
    task automatic addRow(logic [31:0] word, int kind, logic [31:0] where, logic [31:0] value);
        rowWord[rowCount] = word;
        rowTest[rowCount] = curTest;
        rowKind[rowCount] = (skipCount == 0) ? kind : kindNone;
        rowWhere[rowCount] = where;
        rowValue[rowCount] = value;
        if (skipCount > 0) begin
            skipCount--;
        end
        rowCount++;
        testPos++;
    endtask

    task automatic aluRow(logic [5:0] fn, int rd, int rs, int rt, int shamt);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        a = model[rs];
        b = model[rt];
        case (fn)
            cpuPkg::fnAdd: result = a + b;
            cpuPkg::fnSub: result = a - b;
            cpuPkg::fnAnd: result = a & b;
            cpuPkg::fnOr:  result = a | b;
            cpuPkg::fnSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:       result = b << shamt;
        endcase
        if (skipCount == 0 && rd != 0) begin
            model[rd] = result;
        end
        addRow(rWord(fn, rs, rt, rd, shamt), (rd != 0) ? kindReg : kindNone, 32'(rd), result);
    endtask

    task automatic addiRow(int rt, int rs, logic [15:0] imm);
        logic [31:0] result;
        result = model[rs] + signExtend(imm);
        if (skipCount == 0 && rt != 0) begin
            model[rt] = result;
        end
        addRow(iWord(cpuPkg::opAddi, rs, rt, imm), kindReg, 32'(rt), result);
    endtask

    task automatic storeRow(int rt, int rs, logic [15:0] imm);
        logic [31:0] addr;
        addr = model[rs] + signExtend(imm);
        if (skipCount == 0) begin
            modelMem[addr[7:2]] = model[rt];
        end
        addRow(iWord(cpuPkg::opSw, rs, rt, imm), kindStore, addr, model[rt]);
    endtask

    task automatic loadRow(int rt, int rs, logic [15:0] imm);
        logic [31:0] addr;
        logic [31:0] result;
        addr = model[rs] + signExtend(imm);
        result = modelMem[addr[7:2]];
        if (skipCount == 0 && rt != 0) begin
            model[rt] = result;
        end
        addRow(iWord(cpuPkg::opLw, rs, rt, imm), kindReg, 32'(rt), result);
    endtask

    task automatic beqRow(int rs, int rt, int offset);
        logic taken;
        taken = (skipCount == 0) && (model[rs] == model[rt]);
        addRow(iWord(cpuPkg::opBeq, rs, rt, 16'(offset)), kindNone, '0, '0);
        if (taken) begin
            skipCount = offset;
        end
    endtask

    task automatic jumpRow(int index);
        logic live;
        live = (skipCount == 0);
        addRow({cpuPkg::opJ, 26'(index)}, kindNone, '0, '0);
        if (live) begin
            skipCount = index - testPos;
        end
    endtask

    task automatic haltRow();
        addRow({cpuPkg::opHalt, 26'd0}, kindNone, '0, '0);
        skipCount = maxRows;
    endtask

    task automatic buildTable();
        integer rnd;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        // Dependent ALU chain. Each instruction uses the result of the one before it.
        newTest(1);
        addiRow(1, 0, 16'd25);
        addiRow(2, 0, 16'hfff9);
        aluRow(cpuPkg::fnAdd, 3, 1, 2, 0);
        aluRow(cpuPkg::fnSub, 4, 3, 1, 0);
        aluRow(cpuPkg::fnAnd, 5, 4, 3, 0);
        aluRow(cpuPkg::fnOr, 6, 5, 2, 0);
        aluRow(cpuPkg::fnSlt, 7, 6, 5, 0);
        aluRow(cpuPkg::fnSll, 8, 0, 7, 4);
        haltRow();
        newTest(2);
        rnd = $random(seed);
        addiRow(9, 0, rnd[15:0]);
        for (int k = 0; k < 5; k++) begin
            rnd = $random(seed);
            addiRow(9, 9, rnd[15:0]);
        end
        haltRow();
        newTest(3);
        addiRow(10, 0, 16'h1234);
        addiRow(11, 0, 16'd8);
        storeRow(10, 11, 16'd4);
        loadRow(12, 11, 16'd4);
        aluRow(cpuPkg::fnAdd, 13, 12, 10, 0);
        haltRow();
        // Both branches test a register written just before them.
        newTest(4);
        addiRow(14, 0, 16'd5);
        addiRow(15, 0, 16'd5);
        beqRow(14, 15, 1);
        addiRow(16, 0, 16'd99);
        addiRow(17, 0, 16'd7);
        beqRow(17, 14, 1);
        addiRow(18, 0, 16'd3);
        haltRow();
        newTest(5);
        addiRow(19, 0, 16'd11);
        jumpRow(4);
        addiRow(20, 0, 16'd1);
        addiRow(21, 0, 16'd2);
        aluRow(cpuPkg::fnAdd, 22, 19, 19, 0);
        haltRow();
        addiRow(23, 0, 16'd5);
    endtask

    task automatic loadProgram(int t);
        int addr;
        addr = 0;
        for (int i = 0; i < rowCount; i++) begin
            if (rowTest[i] == t) begin
                @(negedge clock);
                loadValid = 1'b1;
                loadAddr = 6'(addr);
                loadData = rowWord[i];
                while (!loadReady) begin
                    @(negedge clock);
                end
                addr++;
            end
        end
        @(negedge clock);
        loadValid = 1'b0;
    endtask

    // Register writes and stores on the DUT ports this cycle.
    task automatic recordRetirement();
        if (wbValid) begin
            evKind.push_back(kindReg);
            evWhere.push_back(32'(wbReg));
            evValue.push_back(wbValue);
        end
        if (storeValid) begin
            evKind.push_back(kindStore);
            evWhere.push_back(storeAddr);
            evValue.push_back(storeData);
        end
    endtask

    // With offer set, a word that would change the program sits on the load port.
    task automatic runProgram(logic offer);
        evKind.delete();
        evWhere.delete();
        evValue.delete();
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        if (offer) begin
            loadValid = 1'b1;
            loadAddr = 6'd4;
            loadData = iWord(cpuPkg::opAddi, 0, 22, 16'h7777);
        end
        while (!done) begin
            checkValue("loadReady while running", 32'(loadReady), 32'd0);
            recordRetirement();
            @(negedge clock);
        end
        loadValid = 1'b0;
        // A word fetched past the halt would retire within three cycles of done.
        repeat (3) begin
            checkValue("done after halt", 32'(done), 32'd1);
            recordRetirement();
            @(negedge clock);
        end
    endtask

    task automatic checkProgram(int t, int errorsBefore);
        int n;
        n = 0;
        for (int i = 0; i < rowCount; i++) begin
            if (rowTest[i] == t && rowKind[i] != kindNone) begin
                if (n >= evKind.size()) begin
                    $display("test %0d: expected write %0d never happened", t, n);
                    errorCount++;
                end else begin
                    checkValue($sformatf("test %0d event %0d kind", t, n), evKind[n], rowKind[i]);
                    checkValue($sformatf("test %0d event %0d target", t, n), evWhere[n],
                               rowWhere[i]);
                    checkValue($sformatf("test %0d event %0d value", t, n), evValue[n],
                               rowValue[i]);
                end
                n++;
            end
        end
        if (evKind.size() > n) begin
            $display("test %0d: %0d extra writes or stores retired", t, evKind.size() - n);
            errorCount++;
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %0d passed with %0d writes", t, n);
        end else begin
            failCount++;
            $display("test %0d failed", t);
        end
    endtask

    initial begin
        int errorsBefore;
        clock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        loadValid = 1'b0;
        loadAddr = '0;
        loadData = '0;
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        rowCount = 0;
        tableReady = 1'b0;
        seed = 65;
        buildTable();
        tableReady = 1'b1;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int t = 1; t <= 5; t++) begin
            errorsBefore = errorCount;
            loadProgram(t);
            runProgram(t == 5);
            checkProgram(t, errorsBefore);
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Sixty cycles per program word.
    initial begin
        wait (tableReady);
        #(rowCount * 60 * clockPeriod);
        $display("TIMEOUT: the programs did not finish within %0d cycles", rowCount * 60);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* logic/cpu.sv */
`timescale 1ns/1ps

module cpu #(
    parameter int imemDepth = 64,
    parameter int dmemDepth = 64
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         loadValid,
    input  logic [$clog2(imemDepth)-1:0] loadAddr,
    input  logic [31:0]                  loadData,
    output logic                         loadReady,
    output logic                         wbValid,
    output logic [4:0]                   wbReg,
    output logic [31:0]                  wbValue,
    output logic                         storeValid,
    output logic [31:0]                  storeAddr,
    output logic [31:0]                  storeData,
    output logic                         done
);
    cpuPkg::fetchToDecodeT   fetchOut;
    cpuPkg::fetchToDecodeT   decodeIn;
    cpuPkg::decodeToExecuteT decodeOut;
    cpuPkg::decodeToExecuteT executeIn;
    cpuPkg::fwdSelT          forwardA;
    cpuPkg::fwdSelT          forwardB;

    // Decode and hazard signals.
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic        flushDecode;
    logic [4:0]  rsId;
    logic [4:0]  rtId;
    logic        isBranch;
    logic        stallFetch;
    logic        stallDecode;
    logic        flushExecute;

    // Execute to memory.
    logic [31:0] aluOut;
    logic [31:0] writeData;
    logic [4:0]  writeReg;
    logic        regWrite;
    logic        memToReg;
    logic        memWrite;
    logic        halt;
    logic        haltSeen;

    fetchStage #(.imemDepth(imemDepth)) fetch (
        .clock(clock), .reset(reset), .start(start),
        .loadValid(loadValid), .loadAddr(loadAddr), .loadData(loadData),
        .loadReady(loadReady), .stallFetch(stallFetch),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .haltSeen(haltSeen), .done(done), .fetchOut(fetchOut)
    );

    pipeReg #(.payloadT(cpuPkg::fetchToDecodeT)) fetchDecodeReg (
        .clock(clock), .reset(reset), .stall(stallDecode), .flush(flushDecode),
        .dataIn(fetchOut), .dataOut(decodeIn)
    );

    decodeStage decode (
        .clock(clock), .reset(reset), .fetchIn(decodeIn),
        .wbValid(wbValid), .wbReg(wbReg), .wbValue(wbValue),
        .decodeOut(decodeOut), .rsId(rsId), .rtId(rtId), .isBranch(isBranch),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .flushDecode(flushDecode)
    );

    // Nothing stalls execute; a branch stall only feeds it bubbles.
    pipeReg #(.payloadT(cpuPkg::decodeToExecuteT)) decodeExecuteReg (
        .clock(clock), .reset(reset), .stall(1'b0), .flush(flushExecute),
        .dataIn(decodeOut), .dataOut(executeIn)
    );

    executeStage execute (
        .executeIn(executeIn), .forwardA(forwardA), .forwardB(forwardB),
        .memResult(wbValue), .aluOut(aluOut), .writeData(writeData),
        .writeReg(writeReg), .regWrite(regWrite), .memToReg(memToReg),
        .memWrite(memWrite), .halt(halt)
    );

    memStage #(.dmemDepth(dmemDepth)) mem (
        .clock(clock), .reset(reset), .aluOut(aluOut), .writeData(writeData),
        .writeReg(writeReg), .regWrite(regWrite), .memToReg(memToReg),
        .memWrite(memWrite), .halt(halt), .wbValid(wbValid), .wbReg(wbReg),
        .wbValue(wbValue), .storeValid(storeValid), .storeAddr(storeAddr),
        .storeData(storeData), .haltSeen(haltSeen)
    );

    hazardUnit hazard (
        .rsId(rsId), .rtId(rtId), .isBranch(isBranch),
        .executeRs(executeIn.rs), .executeRt(executeIn.rt),
        .executeWriteReg(writeReg), .executeRegWrite(regWrite),
        .wbReg(wbReg), .wbValid(wbValid), .forwardA(forwardA), .forwardB(forwardB),
        .stallFetch(stallFetch), .stallDecode(stallDecode), .flushExecute(flushExecute)
    );

endmodule

/* logic/cpuPkg.sv */
package cpuPkg;

    // Primary opcodes, instruction bits 31:26.
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opHalt  = 6'h3f;

    // Function codes of R-type instructions, bits 5:0.
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;
    localparam logic [5:0] fnSll = 6'h00;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll
    } aluOpT;

    // Source of an execute operand.
    typedef enum logic {
        fwdNone,
        fwdMem
    } fwdSelT;

    typedef struct packed {
        logic [31:0] instruction;
        logic [31:0] pcPlusFour;
        logic        valid;
    } fetchToDecodeT;

    typedef struct packed {
        logic        regWrite;
        logic        memToReg;
        logic        memWrite;
        logic        aluSrc;
        logic        regDst;
        logic        halt;
        aluOpT       aluOp;
        logic [31:0] rsValue;
        logic [31:0] rtValue;
        logic [31:0] immediate;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
    } decodeToExecuteT;

endpackage

/* logic/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic                    clock,
    input  logic                    reset,
    input  cpuPkg::fetchToDecodeT   fetchIn,
    input  logic                    wbValid,
    input  logic [4:0]              wbReg,
    input  logic [31:0]             wbValue,
    output cpuPkg::decodeToExecuteT decodeOut,
    output logic [4:0]              rsId,
    output logic [4:0]              rtId,
    output logic                    isBranch,
    output logic                    branchTaken,
    output logic [31:0]             branchTarget,
    output logic                    flushDecode
);
    logic [31:0] regFile [32];
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [31:0] immediate;
    logic [31:0] rsValue;
    logic [31:0] rtValue;
    logic        isJump;

    assign opcode    = fetchIn.instruction[31:26];
    assign funct     = fetchIn.instruction[5:0];
    assign rsId      = fetchIn.instruction[25:21];
    assign rtId      = fetchIn.instruction[20:16];
    assign immediate = {{16{fetchIn.instruction[15]}}, fetchIn.instruction[15:0]};

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbValid && wbReg != 5'd0) begin
            regFile[wbReg] <= wbValue;
        end
    end

    // Write-first read, so a value retiring this cycle is seen here.
    assign rsValue = (rsId == 5'd0) ? '0 :
                     (wbValid && wbReg == rsId) ? wbValue : regFile[rsId];
    assign rtValue = (rtId == 5'd0) ? '0 :
                     (wbValid && wbReg == rtId) ? wbValue : regFile[rtId];

    always_comb begin
        decodeOut           = '0;
        decodeOut.rsValue   = rsValue;
        decodeOut.rtValue   = rtValue;
        decodeOut.immediate = immediate;
        decodeOut.rs        = rsId;
        decodeOut.rt        = rtId;
        decodeOut.rd        = fetchIn.instruction[15:11];
        decodeOut.shamt     = fetchIn.instruction[10:6];
        isBranch            = 1'b0;
        isJump              = 1'b0;
        if (fetchIn.valid) begin
            case (opcode)
                cpuPkg::opRType: begin
                    decodeOut.regWrite = 1'b1;
                    decodeOut.regDst   = 1'b1;
                    case (funct)
                        cpuPkg::fnAdd: decodeOut.aluOp = cpuPkg::aluAdd;
                        cpuPkg::fnSub: decodeOut.aluOp = cpuPkg::aluSub;
                        cpuPkg::fnAnd: decodeOut.aluOp = cpuPkg::aluAnd;
                        cpuPkg::fnOr:  decodeOut.aluOp = cpuPkg::aluOr;
                        cpuPkg::fnSlt: decodeOut.aluOp = cpuPkg::aluSlt;
                        cpuPkg::fnSll: decodeOut.aluOp = cpuPkg::aluSll;
                        // Unknown function codes retire as no-ops.
                        default: decodeOut.regWrite = 1'b0;
                    endcase
                end
                cpuPkg::opAddi: begin
                    decodeOut.regWrite = 1'b1;
                    decodeOut.aluSrc   = 1'b1;
                end
                cpuPkg::opLw: begin
                    decodeOut.regWrite = 1'b1;
                    decodeOut.memToReg = 1'b1;
                    decodeOut.aluSrc   = 1'b1;
                end
                cpuPkg::opSw: begin
                    decodeOut.memWrite = 1'b1;
                    decodeOut.aluSrc   = 1'b1;
                end
                cpuPkg::opBeq:  isBranch = 1'b1;
                cpuPkg::opJ:    isJump = 1'b1;
                cpuPkg::opHalt: decodeOut.halt = 1'b1;
                default: ;
            endcase
        end
    end

    assign branchTaken  = (isBranch && rsValue == rtValue) || isJump;
    assign branchTarget = isJump ?
        {fetchIn.pcPlusFour[31:28], fetchIn.instruction[25:0], 2'b00} :
        fetchIn.pcPlusFour + {immediate[29:0], 2'b00};

    // The word fetched behind a taken branch or jump is dropped.
    assign flushDecode = branchTaken;

endmodule

/* logic/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  cpuPkg::decodeToExecuteT executeIn,
    input  cpuPkg::fwdSelT          forwardA,
    input  cpuPkg::fwdSelT          forwardB,
    input  logic [31:0]             memResult,
    output logic [31:0]             aluOut,
    output logic [31:0]             writeData,
    output logic [4:0]              writeReg,
    output logic                    regWrite,
    output logic                    memToReg,
    output logic                    memWrite,
    output logic                    halt
);
    logic [31:0] srcA;
    logic [31:0] srcB;

    assign srcA = (forwardA == cpuPkg::fwdMem) ? memResult : executeIn.rsValue;

    // The forwarded rt value is also the store data.
    assign writeData = (forwardB == cpuPkg::fwdMem) ? memResult : executeIn.rtValue;
    assign srcB      = executeIn.aluSrc ? executeIn.immediate : writeData;

    always_comb begin
        case (executeIn.aluOp)
            cpuPkg::aluAdd: aluOut = srcA + srcB;
            cpuPkg::aluSub: aluOut = srcA - srcB;
            cpuPkg::aluAnd: aluOut = srcA & srcB;
            cpuPkg::aluOr:  aluOut = srcA | srcB;
            cpuPkg::aluSlt: aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
            cpuPkg::aluSll: aluOut = srcB << executeIn.shamt;
            default:        aluOut = srcA + srcB;
        endcase
    end

    assign writeReg = executeIn.regDst ? executeIn.rd : executeIn.rt;
    assign regWrite = executeIn.regWrite;
    assign memToReg = executeIn.memToReg;
    assign memWrite = executeIn.memWrite;
    assign halt     = executeIn.halt;

endmodule

/* logic/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage #(
    parameter int imemDepth = 64
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         loadValid,
    input  logic [$clog2(imemDepth)-1:0] loadAddr,
    input  logic [31:0]                  loadData,
    output logic                         loadReady,
    input  logic                         stallFetch,
    input  logic                         branchTaken,
    input  logic [31:0]                  branchTarget,
    input  logic                         haltSeen,
    output logic                         done,
    output cpuPkg::fetchToDecodeT        fetchOut
);
    localparam int addrWidth = $clog2(imemDepth);

    typedef enum logic [1:0] {
        idle,
        running,
        draining
    } runStateT;

    runStateT    state;
    logic [31:0] pc;
    logic [31:0] imem [imemDepth];
    logic [31:0] instruction;
    logic        haltFetched;

    // Program words can only be loaded while the core sits idle.
    assign loadReady = (state == idle);

    assign instruction = imem[pc[addrWidth+1:2]];

    // A halt behind a taken branch is squashed, so it must not stop fetching.
    assign haltFetched = (instruction[31:26] == cpuPkg::opHalt) && !stallFetch && !branchTaken;

    assign fetchOut = '{
        instruction: instruction,
        pcPlusFour:  pc + 32'd4,
        valid:       (state == running)
    };

    always_ff @(posedge clock) begin
        if (loadValid && loadReady) begin
            imem[loadAddr] <= loadData;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
            pc    <= '0;
            done  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= running;
                        pc    <= '0;
                        done  <= 1'b0;
                    end
                end
                running: begin
                    if (haltFetched) begin
                        state <= draining;
                    end
                    // A stalled branch may still hold stale operands.
                    if (!stallFetch) begin
                        pc <= branchTaken ? branchTarget : pc + 32'd4;
                    end
                end
                draining: begin
                    if (haltSeen) begin
                        state <= idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* logic/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    input  logic           [4:0] rsId,
    input  logic           [4:0] rtId,
    input  logic                 isBranch,
    input  logic           [4:0] executeRs,
    input  logic           [4:0] executeRt,
    input  logic           [4:0] executeWriteReg,
    input  logic                 executeRegWrite,
    input  logic           [4:0] wbReg,
    input  logic                 wbValid,
    output cpuPkg::fwdSelT       forwardA,
    output cpuPkg::fwdSelT       forwardB,
    output logic                 stallFetch,
    output logic                 stallDecode,
    output logic                 flushExecute
);
    logic memHit;
    logic branchStall;

    assign memHit = wbValid && (wbReg != 5'd0);

    assign forwardA = (memHit && wbReg == executeRs) ? cpuPkg::fwdMem : cpuPkg::fwdNone;
    assign forwardB = (memHit && wbReg == executeRt) ? cpuPkg::fwdMem : cpuPkg::fwdNone;

    // Beq compares in decode, one stage ahead of any forwarding path.
    assign branchStall = isBranch && executeRegWrite && (executeWriteReg != 5'd0) &&
                         (executeWriteReg == rsId || executeWriteReg == rtId);

    assign stallFetch   = branchStall;
    assign stallDecode  = branchStall;
    assign flushExecute = branchStall;

endmodule

/* logic/memStage.sv */
`timescale 1ns/1ps

module memStage #(
    parameter int dmemDepth = 64
) (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] aluOut,
    input  logic [31:0] writeData,
    input  logic [4:0]  writeReg,
    input  logic        regWrite,
    input  logic        memToReg,
    input  logic        memWrite,
    input  logic        halt,
    output logic        wbValid,
    output logic [4:0]  wbReg,
    output logic [31:0] wbValue,
    output logic        storeValid,
    output logic [31:0] storeAddr,
    output logic [31:0] storeData,
    output logic        haltSeen
);
    localparam int addrWidth = $clog2(dmemDepth);

    logic        regWriteM;
    logic        memToRegM;
    logic        memWriteM;
    logic        haltM;
    logic [31:0] aluOutM;
    logic [31:0] writeDataM;
    logic [4:0]  writeRegM;
    logic [31:0] dmem [dmemDepth];
    logic [31:0] loadWord;

    always_ff @(posedge clock) begin
        if (reset) begin
            regWriteM <= 1'b0;
            memToRegM <= 1'b0;
            memWriteM <= 1'b0;
            haltM     <= 1'b0;
        end else begin
            regWriteM <= regWrite;
            memToRegM <= memToReg;
            memWriteM <= memWrite;
            haltM     <= halt;
        end
    end

    always_ff @(posedge clock) begin
        aluOutM    <= aluOut;
        writeDataM <= writeData;
        writeRegM  <= writeReg;
    end

    // Word addressed, the low two address bits are ignored.
    always_ff @(posedge clock) begin
        if (memWriteM) begin
            dmem[aluOutM[addrWidth+1:2]] <= writeDataM;
        end
    end

    assign loadWord = dmem[aluOutM[addrWidth+1:2]];

    assign wbValid    = regWriteM && (writeRegM != 5'd0);
    assign wbReg      = writeRegM;
    assign wbValue    = memToRegM ? loadWord : aluOutM;
    assign storeValid = memWriteM;
    assign storeAddr  = aluOutM;
    assign storeData  = writeDataM;
    assign haltSeen   = haltM;

endmodule

/* logic/pipeReg.sv */
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  payloadT dataIn,
    output payloadT dataOut
);

    // Stall wins over flush, so a branch waiting on its operands stays put.
    always_ff @(posedge clock) begin
        if (reset) begin
            dataOut <= '0;
        end else if (!stall) begin
            if (flush) begin
                dataOut <= '0;
            end else begin
                dataOut <= dataIn;
            end
        end
    end

endmodule

/* mipsCore.f */
logic/cpuPkg.sv
logic/pipeReg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memStage.sv
logic/hazardUnit.sv
logic/cpu.sv
dv/cpuTb.sv
